/* Makefile */
TOP := tb_fetch_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

/* files.f */
hw/core_pkg.sv
hw/obi_pkg.sv
hw/obi_if.sv
hw/pc_controller.sv
hw/obi_fetch.sv
hw/if_stage.sv
hw/fetch_top.sv
sim/fetch_asserts.sv
sim/tb_fetch_top.sv

/* hw/core_pkg.sv */
package core_pkg;

    ////////////////////////////////////////
    // Core word sizes
    ////////////////////////////////////////

    // Register and address width of the RV32 core
    localparam int unsigned XLEN = 32;

    // Instruction length in bytes, no compressed support
    localparam int unsigned INSN_BYTES = 4;

    ////////////////////////////////////////
    // Core-side types
    ////////////////////////////////////////

    // Byte address of an instruction
    typedef logic [XLEN-1:0] addr_t;

    // Raw 32 bit instruction word as handed to decode
    typedef logic [8*INSN_BYTES-1:0] insn_t;

endpackage : core_pkg

/* hw/fetch_top.sv */
module fetch_top #(
    parameter core_pkg::addr_t BOOT_ADDR = 32'h0000_0080
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_if_i,
    // Redirects
    input  logic              trap_id_i,
    input  logic              trap_ex_i,
    input  logic              mret_i,
    input  logic              branch_taken_ex_i,
    input  logic              jump_id_i,
    input  core_pkg::addr_t   mtvec_i,
    input  core_pkg::addr_t   mepc_i,
    input  core_pkg::addr_t   branch_target_ex_i,
    input  core_pkg::addr_t   jump_target_id_i,
    // OBI instruction port, read only
    output logic              insn_obi_req_o,
    input  logic              insn_obi_gnt_i,
    output obi_pkg::obi_addr_t insn_obi_addr_o,
    input  logic              insn_obi_rvalid_i,
    output logic              insn_obi_rready_o,
    input  obi_pkg::obi_data_t insn_obi_rdata_i,
    // To decode
    output core_pkg::addr_t   pc_if_o,
    output core_pkg::insn_t   instr_if_o,
    output logic              valid_if_o
);

    obi_if insn_bus ();

    // Memory side of the bus comes from the pins
    assign insn_bus.gnt    = insn_obi_gnt_i;
    assign insn_bus.rvalid = insn_obi_rvalid_i;
    assign insn_bus.rdata  = insn_obi_rdata_i;

    // Fetch side goes back out
    assign insn_obi_req_o    = insn_bus.req;
    assign insn_obi_addr_o   = insn_bus.addr;
    assign insn_obi_rready_o = insn_bus.rready;

    if_stage #(
        .BOOT_ADDR ( BOOT_ADDR )
    ) if_stage_i (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .stall_if_i         ( stall_if_i         ),
        .trap_id_i          ( trap_id_i          ),
        .trap_ex_i          ( trap_ex_i          ),
        .mret_i             ( mret_i             ),
        .branch_taken_ex_i  ( branch_taken_ex_i  ),
        .jump_id_i          ( jump_id_i          ),
        .mtvec_i            ( mtvec_i            ),
        .mepc_i             ( mepc_i             ),
        .branch_target_ex_i ( branch_target_ex_i ),
        .jump_target_id_i   ( jump_target_id_i   ),
        .bus                ( insn_bus.manager   ),
        .pc_if_o            ( pc_if_o            ),
        .instr_if_o         ( instr_if_o         ),
        .valid_if_o         ( valid_if_o         )
    );

endmodule : fetch_top

/* hw/if_stage.sv */
module if_stage #(
    parameter core_pkg::addr_t BOOT_ADDR = 32'h0000_0080
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            stall_if_i,
    // Redirect strobes and their targets
    input  logic            trap_id_i,
    input  logic            trap_ex_i,
    input  logic            mret_i,
    input  logic            branch_taken_ex_i,
    input  logic            jump_id_i,
    input  core_pkg::addr_t mtvec_i,
    input  core_pkg::addr_t mepc_i,
    input  core_pkg::addr_t branch_target_ex_i,
    input  core_pkg::addr_t jump_target_id_i,
    // Instruction bus
    obi_if.manager          bus,
    // To decode
    output core_pkg::addr_t pc_if_o,
    output core_pkg::insn_t instr_if_o,
    output logic            valid_if_o
);

    import core_pkg::*;

    addr_t pc_q;
    addr_t next_pc;
    addr_t redirect_target;
    addr_t resp_addr;
    insn_t resp_insn;
    logic  redirect;
    logic  grant_taken;
    logic  resp_valid;

    // Fetch starts on a word boundary
    if (BOOT_ADDR[1:0] != 2'b00) begin : g_boot_align
        $error("BOOT_ADDR must be word aligned");
    end

    ////////////////////////////////////////
    // Fetch PC
    ////////////////////////////////////////

    // Redirect wins over a grant in the same cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= BOOT_ADDR;
        end else if (redirect) begin
            pc_q <= redirect_target;
        end else if (grant_taken) begin
            pc_q <= next_pc;
        end
    end

    pc_controller pc_ctrl_i (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .cur_pc_i           ( pc_q               ),
        .trap_id_i          ( trap_id_i          ),
        .trap_ex_i          ( trap_ex_i          ),
        .mret_i             ( mret_i             ),
        .branch_taken_ex_i  ( branch_taken_ex_i  ),
        .jump_id_i          ( jump_id_i          ),
        .mtvec_i            ( mtvec_i            ),
        .mepc_i             ( mepc_i             ),
        .branch_target_ex_i ( branch_target_ex_i ),
        .jump_target_id_i   ( jump_target_id_i   ),
        .grant_taken_i      ( grant_taken        ),
        .next_pc_o          ( next_pc            ),
        .redirect_o         ( redirect           ),
        .redirect_target_o  ( redirect_target    )
    );

    obi_fetch obi_fetch_i (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .fetch_addr_i  ( pc_q        ),
        .stall_i       ( stall_if_i  ),
        .flush_i       ( redirect    ),
        .bus           ( bus         ),
        .grant_taken_o ( grant_taken ),
        .resp_valid_o  ( resp_valid  ),
        .resp_insn_o   ( resp_insn   ),
        .resp_addr_o   ( resp_addr   )
    );

    ////////////////////////////////////////
    // Decode output
    ////////////////////////////////////////

    // One cycle strobe, the cycle after rvalid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_if_o <= 1'b0;
        end else begin
            valid_if_o <= resp_valid;
        end
    end

    // Payload that goes with the strobe
    always_ff @(posedge clk_i) begin
        if (resp_valid) begin
            pc_if_o    <= resp_addr;
            instr_if_o <= resp_insn;
        end
    end

endmodule : if_stage

/* hw/obi_fetch.sv */
module obi_fetch (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Address of the next instruction to fetch
    input  core_pkg::addr_t fetch_addr_i,
    input  logic            stall_i,
    // Redirect, kills everything already on the bus
    input  logic            flush_i,
    obi_if.manager          bus,
    output logic            grant_taken_o,
    output logic            resp_valid_o,
    output core_pkg::insn_t resp_insn_o,
    output core_pkg::addr_t resp_addr_o
);

    import obi_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    obi_addr_t    addr_q;
    logic         kill_q;
    logic         issue;
    logic         granted;
    logic         resp_seen;

    ////////////////////////////////////////
    // Handshake events
    ////////////////////////////////////////

    // No new request in a flush cycle, the PC is about to change
    assign issue     = (state_q == IDLE) && !stall_i && !flush_i;
    assign granted   = (state_q == WAIT_GNT) && bus.gnt;
    assign resp_seen = (state_q == WAIT_RVALID) && bus.rvalid;

    // One outstanding read at most
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (issue) begin
                    state_d = WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                // Req stays up until gnt, even under stall or flush
                if (bus.gnt) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (bus.rvalid) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address captured at issue and held through the transaction
    always_ff @(posedge clk_i) begin
        if (issue) begin
            addr_q <= fetch_addr_i;
        end
    end

    ////////////////////////////////////////
    // Flush tracking
    ////////////////////////////////////////

    // Marks a request that is waiting for gnt or already granted
    // Cleared once its response has been swallowed
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            kill_q <= 1'b0;
        end else if (resp_seen) begin
            kill_q <= 1'b0;
        end else if (flush_i && (state_q != IDLE)) begin
            kill_q <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Bus and core outputs
    ////////////////////////////////////////

    assign bus.req    = (state_q == WAIT_GNT);
    assign bus.addr   = addr_q;
    // Responses are never back-pressured
    assign bus.rready = 1'b1;

    // Only grants of live requests move the PC
    assign grant_taken_o = granted && !kill_q && !flush_i;

    // Killed responses are consumed without a strobe
    assign resp_valid_o = resp_seen && !kill_q && !flush_i;
    assign resp_insn_o  = bus.rdata;
    assign resp_addr_o  = addr_q;

endmodule : obi_fetch

/* hw/obi_if.sv */
interface obi_if;

    import obi_pkg::*;

    // Address phase
    logic      req;
    logic      gnt;
    obi_addr_t addr;

    // Response phase
    logic      rvalid;
    logic      rready;
    obi_data_t rdata;

    // Fetch side, issues reads only
    modport manager (
        output req,
        output addr,
        output rready,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    // Memory side
    modport subordinate (
        input  req,
        input  addr,
        input  rready,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface : obi_if

/* hw/obi_pkg.sv */
package obi_pkg;

    ////////////////////////////////////////
    // OBI instruction bus widths
    ////////////////////////////////////////

    localparam int unsigned OBI_AW = 32;
    localparam int unsigned OBI_DW = 32;

    // Bus address and read data
    typedef logic [OBI_AW-1:0] obi_addr_t;
    typedef logic [OBI_DW-1:0] obi_data_t;

    ////////////////////////////////////////
    // Fetch manager state
    ////////////////////////////////////////

    // IDLE        nothing on the bus
    // WAIT_GNT    req raised, address held until gnt
    // WAIT_RVALID request accepted, waiting for its response
    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        WAIT_RVALID
    } fetch_state_t;

endpackage : obi_pkg

/* hw/pc_controller.sv */
module pc_controller (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  core_pkg::addr_t cur_pc_i,
    // Redirect strobes, one cycle each
    input  logic            trap_id_i,
    input  logic            trap_ex_i,
    input  logic            mret_i,
    input  logic            branch_taken_ex_i,
    input  logic            jump_id_i,
    // Targets, valid with their strobe
    input  core_pkg::addr_t mtvec_i,
    input  core_pkg::addr_t mepc_i,
    input  core_pkg::addr_t branch_target_ex_i,
    input  core_pkg::addr_t jump_target_id_i,
    // A live request was accepted by the bus
    input  logic            grant_taken_i,
    output core_pkg::addr_t next_pc_o,
    output logic            redirect_o,
    output core_pkg::addr_t redirect_target_o
);

    import core_pkg::*;

    addr_t sel_target;
    addr_t pend_target_q;
    addr_t seq_base;
    logic  redirect_pending_q;

    ////////////////////////////////////////
    // Redirect priority
    ////////////////////////////////////////

    // Trap beats mret, mret beats branch, branch beats jump
    always_comb begin
        sel_target = jump_target_id_i;
        if (trap_id_i || trap_ex_i) begin
            sel_target = mtvec_i;
        end else if (mret_i) begin
            sel_target = mepc_i;
        end else if (branch_taken_ex_i) begin
            sel_target = branch_target_ex_i;
        end
    end

    assign redirect_o = trap_id_i | trap_ex_i | mret_i | branch_taken_ex_i | jump_id_i;

    // Targets are forced to word alignment
    assign redirect_target_o = {sel_target[XLEN-1:2], 2'b00};

    ////////////////////////////////////////
    // Pending redirect
    ////////////////////////////////////////

    // Set by a redirect, consumed by the first live grant after it
    // A newer redirect simply overwrites the held target
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            redirect_pending_q <= 1'b0;
        end else if (redirect_o) begin
            redirect_pending_q <= 1'b1;
        end else if (grant_taken_i) begin
            redirect_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (redirect_o) begin
            pend_target_q <= redirect_target_o;
        end
    end

    // Sequential successor of whatever address the grant took
    assign seq_base  = redirect_pending_q ? pend_target_q : cur_pc_i;
    assign next_pc_o = seq_base + addr_t'(INSN_BYTES);

endmodule : pc_controller

/* sim/fetch_asserts.sv */
module fetch_asserts (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               req_i,
    input logic               gnt_i,
    input obi_pkg::obi_addr_t addr_i,
    input logic               rready_i,
    input logic               valid_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import obi_pkg::*;

    ////////////////////////////////////////
    // OBI address phase
    ////////////////////////////////////////

    // Once raised, req waits for gnt
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i && !gnt_i |=> req_i)
        else $error("req dropped before gnt");

    // Address frozen while the request is pending
    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i && !gnt_i |=> $stable(addr_i))
        else $error("addr changed while waiting for gnt");

    ////////////////////////////////////////
    // Response and decode side
    ////////////////////////////////////////

    rready_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rready_i)
        else $error("rready low after reset");

    // Decode strobe is a single cycle pulse
    valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |=> !valid_i)
        else $error("valid_if_o high for two cycles");

endmodule : fetch_asserts

bind fetch_top fetch_asserts asserts_i (
    .clk_i    ( clk_i             ),
    .rst_n_i  ( rst_n_i           ),
    .req_i    ( insn_obi_req_o    ),
    .gnt_i    ( insn_obi_gnt_i    ),
    .addr_i   ( insn_obi_addr_o   ),
    .rready_i ( insn_obi_rready_o ),
    .valid_i  ( valid_if_o        )
);

/* sim/tb_fetch_top.sv */
module tb_fetch_top;

    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;
    import obi_pkg::*;

    localparam addr_t       BOOT_ADDR      = 32'h0000_0080;
    localparam int unsigned TIMEOUT_CYCLES = 200;

    logic      clk;
    logic      rst_n;
    logic      stall_if;
    logic      trap_id;
    logic      trap_ex;
    logic      mret;
    logic      branch_taken;
    logic      jump;
    addr_t     mtvec;
    addr_t     mepc;
    addr_t     branch_target;
    addr_t     jump_target;
    logic      obi_req;
    logic      obi_gnt;
    obi_addr_t obi_addr;
    logic      obi_rvalid;
    logic      obi_rready;
    obi_data_t obi_rdata;
    addr_t     pc_if;
    insn_t     instr_if;
    logic      valid_if;

    // Expected PC, owned by the compare process
    addr_t       exp_pc     = BOOT_ADDR;
    int unsigned redir_seen = 0;
    int unsigned n_checked  = 0;
    // Redirect handoff from stimulus to compare
    addr_t       redir_target;
    int unsigned redir_count;
    // Forces a zero cycle grant delay in the memory model
    logic        fast_gnt;

    fetch_top #(
        .BOOT_ADDR ( BOOT_ADDR )
    ) dut_i (
        .clk_i              ( clk           ),
        .rst_n_i            ( rst_n         ),
        .stall_if_i         ( stall_if      ),
        .trap_id_i          ( trap_id       ),
        .trap_ex_i          ( trap_ex       ),
        .mret_i             ( mret          ),
        .branch_taken_ex_i  ( branch_taken  ),
        .jump_id_i          ( jump          ),
        .mtvec_i            ( mtvec         ),
        .mepc_i             ( mepc          ),
        .branch_target_ex_i ( branch_target ),
        .jump_target_id_i   ( jump_target   ),
        .insn_obi_req_o     ( obi_req       ),
        .insn_obi_gnt_i     ( obi_gnt       ),
        .insn_obi_addr_o    ( obi_addr      ),
        .insn_obi_rvalid_i  ( obi_rvalid    ),
        .insn_obi_rready_o  ( obi_rready    ),
        .insn_obi_rdata_i   ( obi_rdata     ),
        .pc_if_o            ( pc_if         ),
        .instr_if_o         ( instr_if      ),
        .valid_if_o         ( valid_if      )
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Memory content, address rotated left by 7 then scrambled
    function automatic insn_t mem_word(input addr_t addr);
        return {addr[24:0], addr[31:25]} ^ 32'hA5C3_0F1E;
    endfunction

    // Trap, then mret, then branch, then jump, word aligned
    function automatic addr_t winning_target(input logic trap, input logic ret,
                                             input logic branch, input addr_t tvec,
                                             input addr_t epc, input addr_t br_tgt,
                                             input addr_t jmp_tgt);
        addr_t target;
        if (trap) begin
            target = tvec;
        end else if (ret) begin
            target = epc;
        end else if (branch) begin
            target = br_tgt;
        end else begin
            target = jmp_tgt;
        end
        return {target[31:2], 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $fatal(1, "wait limit reached");
    endtask

    // Drive point, shortly after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////

    initial begin : memory_model
        int unsigned waited;
        int unsigned gnt_delay;
        int unsigned rvalid_delay;
        obi_addr_t   req_addr;
        obi_gnt    = 1'b0;
        obi_rvalid = 1'b0;
        obi_rdata  = '0;
        forever begin
            waited = 0;
            // Only a clean high req starts a transaction
            while (obi_req !== 1'b1 && waited < TIMEOUT_CYCLES) begin
                next_cycle();
                waited++;
            end
            if (obi_req !== 1'b1) begin
                stop_on_timeout("a bus request");
            end
            gnt_delay = fast_gnt ? 0 : $urandom_range(3, 0);
            repeat (gnt_delay) next_cycle();
            obi_gnt  = 1'b1;
            req_addr = obi_addr;
            next_cycle();
            obi_gnt      = 1'b0;
            // Response 1 to 3 cycles after the grant cycle
            rvalid_delay = $urandom_range(3, 1);
            repeat (rvalid_delay - 1) next_cycle();
            obi_rvalid = 1'b1;
            obi_rdata  = mem_word(req_addr);
            next_cycle();
            obi_rvalid = 1'b0;
            obi_rdata  = $urandom();
        end
    end

    ////////////////////////////////////////
    // Compare
    ////////////////////////////////////////

    // Sampled mid cycle, away from the edges
    always @(negedge clk) begin
        if (rst_n) begin
            if (redir_count != redir_seen) begin
                exp_pc     = redir_target;
                redir_seen = redir_count;
            end
            if (valid_if) begin
                check_value("pc_if_o", pc_if, exp_pc);
                check_value("instr_if_o", instr_if, mem_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                n_checked++;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic wait_deliveries(input int unsigned n);
        int unsigned target;
        int unsigned waited;
        target = n_checked + n;
        waited = 0;
        while (n_checked < target && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (n_checked < target) begin
            stop_on_timeout("instruction deliveries");
        end
    endtask

    task automatic wait_req(input logic level);
        int unsigned waited;
        waited = 0;
        while (obi_req !== level && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (obi_req !== level) begin
            stop_on_timeout("the request line to change");
        end
    endtask

    // One cycle strobe, the expected PC moves once the cycle is over
    task automatic fire_redirect(input logic t_id, input logic t_ex, input logic ret,
                                 input logic br, input logic jmp);
        mtvec         = $urandom();
        mepc          = $urandom();
        branch_target = $urandom();
        jump_target   = $urandom();
        trap_id       = t_id;
        trap_ex       = t_ex;
        mret          = ret;
        branch_taken  = br;
        jump          = jmp;
        redir_target  = winning_target(t_id | t_ex, ret, br, mtvec, mepc,
                                       branch_target, jump_target);
        next_cycle();
        trap_id      = 1'b0;
        trap_ex      = 1'b0;
        mret         = 1'b0;
        branch_taken = 1'b0;
        jump         = 1'b0;
        redir_count++;
    endtask

    initial begin
        void'($urandom(32'h6200));
        clk           = 1'b0;
        rst_n         = 1'b0;
        stall_if      = 1'b0;
        trap_id       = 1'b0;
        trap_ex       = 1'b0;
        mret          = 1'b0;
        branch_taken  = 1'b0;
        jump          = 1'b0;
        mtvec         = '0;
        mepc          = '0;
        branch_target = '0;
        jump_target   = '0;
        redir_target  = BOOT_ADDR;
        redir_count   = 0;
        fast_gnt      = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        check_value("insn_obi_req_o", 32'(obi_req), 32'h0);
        check_value("valid_if_o", 32'(valid_if), 32'h0);
        check_value("insn_obi_rready_o", 32'(obi_rready), 32'h1);
        rst_n = 1'b1;

        // Boot address then sequential fetch
        wait_deliveries(10);

        // Jumps at arbitrary points of a transaction
        repeat (4) begin
            repeat ($urandom_range(6, 0)) next_cycle();
            fire_redirect(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
            wait_deliveries(3);
        end

        // Jump in the very cycle the request is granted
        fast_gnt = 1'b1;
        wait_req(1'b0);
        wait_req(1'b1);
        fire_redirect(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        fast_gnt = 1'b0;
        wait_deliveries(3);

        // Same cycle priority
        fire_redirect(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        wait_deliveries(3);
        fire_redirect(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        wait_deliveries(3);
        fire_redirect(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        wait_deliveries(3);

        // Single sources
        fire_redirect(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        wait_deliveries(3);
        fire_redirect(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_deliveries(3);
        fire_redirect(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        wait_deliveries(3);
        fire_redirect(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_deliveries(3);

        // Stall, a raised req may finish but no new one follows
        stall_if = 1'b1;
        wait_req(1'b0);
        repeat (12) begin
            next_cycle();
            check_value("insn_obi_req_o", 32'(obi_req), 32'h0);
        end
        stall_if = 1'b0;
        wait_deliveries(6);

        $display("Test passed");
        $finish;
    end

endmodule : tb_fetch_top
